// File: hdl/threefish_pkg.sv
`default_nettype none

package threefish_pkg;

	typedef logic [63:0] tf_word_t;
	typedef logic [5:0] tf_rot_t;

	typedef struct packed {
		tf_word_t w0;
		tf_word_t w1;
		tf_word_t w2;
		tf_word_t w3;
	} tf_state_t;

	// k4 is the parity word.
	typedef struct packed {
		tf_word_t k0;
		tf_word_t k1;
		tf_word_t k2;
		tf_word_t k3;
		tf_word_t k4;
	} tf_ext_key_t;

	localparam tf_word_t TF_PARITY = 64'h1BD1_1BDA_A9FC_1A22;
	localparam int unsigned TF_ROUNDS = 8;
	localparam int unsigned TF_GROUP_ROUNDS = 4; // rounds per subkey injection.
	localparam int unsigned TF_EXT_WORDS = 5;
	localparam int unsigned TF_FINAL_SUBKEY = TF_ROUNDS / TF_GROUP_ROUNDS;

	// rotations for (w0,w1) and (w2,w3), per round.
	localparam tf_rot_t TF_ROT_TABLE [0:TF_ROUNDS-1][0:1] = '{
		'{6'd14, 6'd16},
		'{6'd52, 6'd57},
		'{6'd23, 6'd40},
		'{6'd5, 6'd37},
		'{6'd25, 6'd33},
		'{6'd46, 6'd12},
		'{6'd58, 6'd22},
		'{6'd32, 6'd32}
	};

	function automatic tf_word_t tf_key_word(tf_ext_key_t ek, int unsigned idx);
		tf_word_t w;
		case (idx % TF_EXT_WORDS)
			0: w = ek.k0;
			1: w = ek.k1;
			2: w = ek.k2;
			3: w = ek.k3;
			default: w = ek.k4;
		endcase
		return w;
	endfunction

	// subkey s added word by word, mod 2^64.
	function automatic tf_state_t tf_inject(tf_state_t st, tf_ext_key_t ek, int unsigned s);
		tf_state_t res;
		res.w0 = st.w0 + tf_key_word(ek, s);
		res.w1 = st.w1 + tf_key_word(ek, s + 1);
		res.w2 = st.w2 + tf_key_word(ek, s + 2);
		res.w3 = st.w3 + tf_key_word(ek, s + 3) + tf_word_t'(s);
		return res;
	endfunction

endpackage

`default_nettype wire

// File: hdl/search_pkg.sv
`default_nettype none

package search_pkg;

	localparam int unsigned SEARCH_W = 256;

	typedef logic [SEARCH_W-1:0] nonce_t;
	typedef logic [SEARCH_W-1:0] hash_t;
	typedef logic [8:0] bits_off_t; // 0 to 256.

	localparam bits_off_t BITS_OFF_MAX = 9'd256;

	typedef struct packed {
		threefish_pkg::tf_state_t state;
		nonce_t nonce; // kept for feed-forward.
	} pipe_stage_t;

	typedef struct packed {
		nonce_t nonce;
		hash_t hash;
		bits_off_t bits_off;
	} search_result_t;

endpackage

`default_nettype wire

// File: hdl/key_schedule.sv
`default_nettype none

module key_schedule (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic load_i,
	input wire logic busy_i,
	input wire threefish_pkg::tf_state_t key_i,
	output threefish_pkg::tf_ext_key_t ext_key_o
);

	import threefish_pkg::*;

	tf_state_t key_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			key_q <= '0;
		end else if (load_i) begin
			key_q <= key_i;
		end
	end

	assign ext_key_o.k0 = key_q.w0;
	assign ext_key_o.k1 = key_q.w1;
	assign ext_key_o.k2 = key_q.w2;
	assign ext_key_o.k3 = key_q.w3;
	assign ext_key_o.k4 = TF_PARITY ^ key_q.w0 ^ key_q.w1 ^ key_q.w2 ^ key_q.w3;

	// all stages share this key, so it must not move under an item in flight.
	a_load_idle: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!(load_i && busy_i)
	) else $error("key load while pipeline busy");

endmodule

`default_nettype wire

// File: hdl/mix_round_group.sv
`default_nettype none

module mix_round_group #(
	parameter int unsigned GROUP = 0
) (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input wire search_pkg::pipe_stage_t stage_i,
	input wire threefish_pkg::tf_ext_key_t ext_key_i,
	output logic valid_o,
	output search_pkg::pipe_stage_t stage_o
);

	import threefish_pkg::*;

	if ((GROUP + 1) * TF_GROUP_ROUNDS > TF_ROUNDS) begin : g_bad_group
		$error("mix_round_group: GROUP %0d out of range", GROUP);
	end

	function automatic tf_word_t rotl(tf_word_t x, tf_rot_t n);
		return (x << n) | (x >> (7'd64 - n));
	endfunction

	// two MIXes, then w1 and w3 trade places.
	function automatic tf_state_t mix_round(tf_state_t st, int unsigned r);
		tf_state_t res;
		tf_word_t a0;
		tf_word_t b0;
		tf_word_t a1;
		tf_word_t b1;
		a0 = st.w0 + st.w1;
		b0 = rotl(st.w1, TF_ROT_TABLE[r][0]) ^ a0;
		a1 = st.w2 + st.w3;
		b1 = rotl(st.w3, TF_ROT_TABLE[r][1]) ^ a1;
		res.w0 = a0;
		res.w1 = b1;
		res.w2 = a1;
		res.w3 = b0;
		return res;
	endfunction

	tf_state_t mixed;

	always_comb begin
		mixed = tf_inject(stage_i.state, ext_key_i, GROUP);
		for (int r = 0; r < TF_GROUP_ROUNDS; r++) begin
			mixed = mix_round(mixed, GROUP * TF_GROUP_ROUNDS + r);
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			stage_o.state <= mixed;
			stage_o.nonce <= stage_i.nonce;
		end
	end

endmodule

`default_nettype wire

// File: hdl/hash_finalize.sv
`default_nettype none

module hash_finalize (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input wire search_pkg::pipe_stage_t stage_i,
	input wire threefish_pkg::tf_ext_key_t ext_key_i,
	output logic valid_o,
	output search_pkg::hash_t hash_o,
	output search_pkg::nonce_t nonce_o
);

	import threefish_pkg::*;
	import search_pkg::*;

	tf_state_t cipher;
	hash_t ff_hash;

	assign cipher = tf_inject(stage_i.state, ext_key_i, TF_FINAL_SUBKEY);

	// feed-forward with the plaintext.
	assign ff_hash = hash_t'(cipher) ^ stage_i.nonce;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			hash_o <= ff_hash;
			nonce_o <= stage_i.nonce;
		end
	end

endmodule

`default_nettype wire

// File: hdl/bits_off_counter.sv
`default_nettype none

module bits_off_counter (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input wire search_pkg::hash_t hash_i,
	input wire search_pkg::nonce_t nonce_i,
	input wire search_pkg::hash_t target_i,
	output logic valid_o,
	output search_pkg::search_result_t result_o
);

	import search_pkg::*;

	hash_t diff;
	bits_off_t count;

	assign diff = hash_i ^ target_i;

	// popcount of the differing bits.
	always_comb begin
		count = '0;
		for (int i = 0; i < SEARCH_W; i++) begin
			count = count + bits_off_t'(diff[i]);
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			result_o.nonce <= nonce_i;
			result_o.hash <= hash_i;
			result_o.bits_off <= count;
		end
	end

	a_count_range: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		valid_o |-> result_o.bits_off <= BITS_OFF_MAX
	) else $error("bits off above maximum");

endmodule

`default_nettype wire

// File: hdl/best_nonce_tracker.sv
`default_nettype none

module best_nonce_tracker (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input wire search_pkg::search_result_t result_i,
	input wire logic clear_i,
	output search_pkg::nonce_t best_nonce_o,
	output search_pkg::bits_off_t best_bits_off_o
);

	import search_pkg::*;

	logic better;

	// strictly lower, ties keep the older nonce.
	assign better = valid_i && (result_i.bits_off < best_bits_off_o);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			best_nonce_o <= '0;
			best_bits_off_o <= BITS_OFF_MAX;
		end else if (clear_i) begin // wins over a same-cycle result.
			best_nonce_o <= '0;
			best_bits_off_o <= BITS_OFF_MAX;
		end else if (better) begin
			best_nonce_o <= result_i.nonce;
			best_bits_off_o <= result_i.bits_off;
		end
	end

	a_monotonic: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!clear_i |=> best_bits_off_o <= $past(best_bits_off_o)
	) else $error("best bits off rose without clear");

endmodule

`default_nettype wire

// File: hdl/nonce_search_core.sv
`default_nettype none

module nonce_search_core (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic key_load_i,
	input wire threefish_pkg::tf_state_t key_i,
	input wire logic nonce_valid_i,
	input wire search_pkg::nonce_t nonce_i,
	input wire search_pkg::hash_t target_i,
	input wire logic best_clear_i,
	output logic result_valid_o,
	output search_pkg::search_result_t result_o,
	output search_pkg::nonce_t best_nonce_o,
	output search_pkg::bits_off_t best_bits_off_o
);

	import threefish_pkg::*;
	import search_pkg::*;

	tf_ext_key_t ext_key;
	pipe_stage_t stage_in;
	pipe_stage_t stage_g0;
	pipe_stage_t stage_g1;
	logic valid_g0;
	logic valid_g1;
	logic valid_fin;
	hash_t hash_fin;
	nonce_t nonce_fin;
	logic busy;

	// plaintext is the nonce itself.
	assign stage_in.state = tf_state_t'(nonce_i);
	assign stage_in.nonce = nonce_i;

	// items still ahead of a subkey injection.
	assign busy = nonce_valid_i | valid_g0 | valid_g1;

	key_schedule i_key_schedule (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.load_i(key_load_i),
		.busy_i(busy),
		.key_i(key_i),
		.ext_key_o(ext_key)
	);

	mix_round_group #(.GROUP(0)) i_group_0 (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(nonce_valid_i),
		.stage_i(stage_in),
		.ext_key_i(ext_key),
		.valid_o(valid_g0),
		.stage_o(stage_g0)
	);

	mix_round_group #(.GROUP(1)) i_group_1 (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_g0),
		.stage_i(stage_g0),
		.ext_key_i(ext_key),
		.valid_o(valid_g1),
		.stage_o(stage_g1)
	);

	hash_finalize i_hash_finalize (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_g1),
		.stage_i(stage_g1),
		.ext_key_i(ext_key),
		.valid_o(valid_fin),
		.hash_o(hash_fin),
		.nonce_o(nonce_fin)
	);

	bits_off_counter i_bits_off_counter (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_fin),
		.hash_i(hash_fin),
		.nonce_i(nonce_fin),
		.target_i(target_i),
		.valid_o(result_valid_o),
		.result_o(result_o)
	);

	best_nonce_tracker i_best_nonce_tracker (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(result_valid_o),
		.result_i(result_o),
		.clear_i(best_clear_i),
		.best_nonce_o(best_nonce_o),
		.best_bits_off_o(best_bits_off_o)
	);

endmodule

`default_nettype wire

// File: sim/tb_nonce_search.sv
`default_nettype none

module tb_nonce_search;

	import threefish_pkg::*;
	import search_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam bits_off_t RESET_BITS_OFF = 9'd256;
	localparam logic [63:0] PARITY = 64'h1BD1_1BDA_A9FC_1A22;
	// rotation pairs of rounds 0 to 7, round 0 in the top bits.
	localparam logic [95:0] ROTS = {6'd14, 6'd16, 6'd52, 6'd57, 6'd23, 6'd40, 6'd5, 6'd37,
		6'd25, 6'd33, 6'd46, 6'd12, 6'd58, 6'd22, 6'd32, 6'd32};

	typedef struct {
		bit load;
		logic [255:0] key;
		nonce_t nonce;
		hash_t target;
		bit clear;
		int gap; // idle cycles before the strobe.
	} vec_t;

	typedef struct {
		int due;
		nonce_t nonce;
		hash_t hash;
		bits_off_t bits_off;
	} exp_t;

	logic clk = 1'b0;
	logic rst_n;
	logic key_load;
	tf_state_t key_in;
	logic nonce_valid;
	nonce_t nonce_in;
	hash_t target;
	logic best_clear;
	logic result_valid;
	search_result_t result;
	nonce_t best_nonce;
	bits_off_t best_bits_off;

	vec_t table_q[$];
	exp_t exp_q[$];
	exp_t prev_exp;
	bit prev_valid = 1'b0;
	logic [31:0] lfsr = 32'he3e3bf75;
	logic [255:0] cur_key = '0;
	nonce_t model_nonce = '0;
	bits_off_t model_bits = RESET_BITS_OFF;
	int cyc = 0;
	int cycle_limit = 0;
	int timeout_cnt = 0;
	int n_mismatch = 0;
	int n_other = 0;

	nonce_search_core i_dut (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.key_load_i(key_load),
		.key_i(key_in),
		.nonce_valid_i(nonce_valid),
		.nonce_i(nonce_in),
		.target_i(target),
		.best_clear_i(best_clear),
		.result_valid_o(result_valid),
		.result_o(result),
		.best_nonce_o(best_nonce),
		.best_bits_off_o(best_bits_off)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		timeout_cnt <= timeout_cnt + 1;
		if (cycle_limit > 0 && timeout_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, %0d results pending", timeout_cnt, exp_q.size());
			$display("sim failed");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [255:0] rand_256();
		logic [255:0] v;
		v = '0;
		for (int i = 0; i < 256; i++) begin
			v = {v[254:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic logic [63:0] rotl64(logic [63:0] x, int n);
		return (x << n) | (x >> (64 - n));
	endfunction

	function automatic hash_t model_hash(logic [255:0] key, nonce_t pt);
		logic [63:0] k [5];
		logic [63:0] w [4];
		logic [63:0] t;
		hash_t ct;
		k[4] = PARITY;
		for (int i = 0; i < 4; i++) begin
			k[i] = key[255-64*i -: 64];
			k[4] = k[4] ^ k[i];
			w[i] = pt[255-64*i -: 64];
		end
		// pass r = 8 only injects the last subkey.
		for (int r = 0; r <= 8; r++) begin
			if (r % 4 == 0) begin
				for (int i = 0; i < 4; i++) begin
					w[i] = w[i] + k[(r / 4 + i) % 5];
				end
				w[3] = w[3] + 64'(r / 4);
			end
			if (r < 8) begin
				w[0] = w[0] + w[1];
				w[1] = rotl64(w[1], ROTS[95-12*r -: 6]) ^ w[0];
				w[2] = w[2] + w[3];
				w[3] = rotl64(w[3], ROTS[89-12*r -: 6]) ^ w[2];
				t = w[1];
				w[1] = w[3];
				w[3] = t;
			end
		end
		ct = {w[0], w[1], w[2], w[3]};
		return ct ^ pt;
	endfunction

	function automatic bits_off_t popcount(logic [255:0] v);
		bits_off_t c;
		c = '0;
		for (int i = 0; i < 256; i++) begin
			c = c + bits_off_t'(v[i]);
		end
		return c;
	endfunction

	// target halfway between two hashes, so both count the same.
	function automatic hash_t tie_target(hash_t ha, hash_t hb);
		hash_t d;
		hash_t t;
		int flips;
		d = ha ^ hb;
		t = ha;
		flips = popcount(d) / 2;
		for (int i = 0; i < 256; i++) begin
			if (d[i] && flips > 0) begin
				t[i] = ~t[i];
				flips--;
			end
		end
		return t;
	endfunction

	task automatic check_value(string name, logic [255:0] got, logic [255:0] want);
		assert (got === want) else begin
			$display("MISMATCH %s: got %0h, expected %0h", name, got, want);
			n_mismatch++;
		end
	endtask

	task automatic report_failure(string what);
		$display("ERROR: %s", what);
		n_other++;
	endtask

	// one clock; checks outputs, then returns all strobes to idle.
	task automatic next_cycle();
		exp_t e;
		@(negedge clk);
		cyc++;
		if (best_clear) begin
			model_nonce = '0;
			model_bits = RESET_BITS_OFF;
		end else if (prev_valid && prev_exp.bits_off < model_bits) begin
			model_nonce = prev_exp.nonce;
			model_bits = prev_exp.bits_off;
		end
		check_value("best_bits_off_o", best_bits_off, model_bits);
		check_value("best_nonce_o", best_nonce, model_nonce);
		prev_valid = 1'b0;
		if (result_valid) begin
			assert (exp_q.size() != 0) else
				report_failure("result_valid_o high with no nonce in flight");
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				assert (e.due == cyc) else
					report_failure($sformatf("result at cycle %0d, due at %0d", cyc, e.due));
				check_value("result_o.nonce", result.nonce, e.nonce);
				check_value("result_o.hash", result.hash, e.hash);
				check_value("result_o.bits_off", result.bits_off, e.bits_off);
				prev_valid = 1'b1;
				prev_exp = e;
			end
		end else begin
			assert (exp_q.size() == 0 || exp_q[0].due > cyc) else begin
				report_failure($sformatf("no result_valid_o at cycle %0d", cyc));
				void'(exp_q.pop_front());
			end
		end
		key_load = 1'b0;
		nonce_valid = 1'b0;
		best_clear = 1'b0;
	endtask

	initial begin
		vec_t v;
		exp_t e;
		logic [255:0] k0;
		logic [255:0] k1;
		hash_t tgt0;
		nonce_t n_rep;
		nonce_t na;
		nonce_t nb;
		hash_t ha;
		hash_t t_tie;
		int max_gap;
		rst_n = 1'b0;
		key_load = 1'b0;
		key_in = '0;
		nonce_valid = 1'b0;
		nonce_in = '0;
		target = '0;
		best_clear = 1'b0;
		k0 = rand_256();
		k1 = rand_256();
		tgt0 = rand_256();
		n_rep = rand_256();
		na = rand_256();
		ha = model_hash(k0, na);
		// an exact tie needs an even distance.
		do begin
			nb = rand_256();
		end while (popcount(ha ^ model_hash(k0, nb)) % 2 != 0);
		t_tie = tie_target(ha, model_hash(k0, nb));
		table_q.push_back(vec_t'{1'b1, k0, n_rep, tgt0, 1'b0, 0});
		repeat (4) begin
			table_q.push_back(vec_t'{1'b0, k0, rand_256(), tgt0, 1'b0, 0});
		end
		// clear meets the result of the second entry.
		table_q.push_back(vec_t'{1'b0, k0, rand_256(), tgt0, 1'b1, 0});
		table_q.push_back(vec_t'{1'b0, k0, rand_256(), tgt0, 1'b0, 2});
		table_q.push_back(vec_t'{1'b0, k0, rand_256(), tgt0, 1'b0, 3});
		table_q.push_back(vec_t'{1'b0, k0, na, t_tie, 1'b1, 1});
		table_q.push_back(vec_t'{1'b0, k0, nb, t_tie, 1'b0, 0});
		table_q.push_back(vec_t'{1'b0, k0, rand_256(), t_tie, 1'b0, 0});
		// first nonce again, new key.
		table_q.push_back(vec_t'{1'b1, k1, n_rep, tgt0, 1'b1, 2});
		table_q.push_back(vec_t'{1'b0, k1, rand_256(), tgt0, 1'b0, 0});
		table_q.push_back(vec_t'{1'b0, k1, rand_256(), tgt0, 1'b0, 1});
		max_gap = 0;
		foreach (table_q[i]) begin
			if (table_q[i].gap > max_gap) begin
				max_gap = table_q[i].gap;
			end
		end
		cycle_limit = table_q.size() * (max_gap + 6) + 50;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		foreach (table_q[i]) begin
			v = table_q[i];
			repeat (v.gap) next_cycle();
			if (v.load || v.target != target) begin
				while (exp_q.size() != 0) begin
					next_cycle();
				end
			end
			next_cycle();
			if (v.load) begin
				key_load = 1'b1;
				key_in = v.key;
				cur_key = v.key;
				next_cycle();
			end
			target = v.target;
			nonce_valid = 1'b1;
			nonce_in = v.nonce;
			best_clear = v.clear;
			e.due = cyc + 4;
			e.nonce = v.nonce;
			e.hash = model_hash(cur_key, v.nonce);
			e.bits_off = popcount(e.hash ^ v.target);
			exp_q.push_back(e);
		end
		repeat (6) next_cycle();
		assert (exp_q.size() == 0) else
			report_failure($sformatf("%0d results never arrived", exp_q.size()));
		$display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
		if (n_mismatch == 0 && n_other == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
hdl/threefish_pkg.sv
hdl/search_pkg.sv
hdl/key_schedule.sv
hdl/mix_round_group.sv
hdl/hash_finalize.sv
hdl/bits_off_counter.sv
hdl/best_nonce_tracker.sv
hdl/nonce_search_core.sv
sim/tb_nonce_search.sv

// File: Bender.yml
package:
  name: nonce_search

sources:
  - hdl/threefish_pkg.sv
  - hdl/search_pkg.sv
  - hdl/key_schedule.sv
  - hdl/mix_round_group.sv
  - hdl/hash_finalize.sv
  - hdl/bits_off_counter.sv
  - hdl/best_nonce_tracker.sv
  - hdl/nonce_search_core.sv
  - target: test
    files:
      - sim/tb_nonce_search.sv
